// File: rtl/adc_stream_pkg.sv
`default_nettype none

package adc_stream_pkg;

  // ******************************
  // stream geometry
  // ******************************

  localparam int ADC_RES          = 12;                      // bits per converter sample
  localparam int LANE_WIDTH       = 16;                      // one sample slot on the stream
  localparam int LANE_NUM         = 8;                       // samples per beat
  localparam int BEAT_WIDTH       = LANE_WIDTH * LANE_NUM;   // full stream word
  localparam int LANE_PAD         = LANE_WIDTH - ADC_RES;    // zero bits under each sample
  localparam int LANE_IDX_WIDTH   = $clog2(LANE_NUM);
  localparam int BEAT_COUNT_WIDTH = 16;

  // ******************************
  // types
  // ******************************

  typedef logic [ADC_RES-1:0]          adc_sample_t;
  typedef logic signed [ADC_RES:0]     ramp_limit_t;  // one extra bit so the ramp limit is signed
  typedef logic [BEAT_WIDTH-1:0]       beat_t;
  typedef logic [LANE_IDX_WIDTH-1:0]   lane_idx_t;
  typedef logic [BEAT_COUNT_WIDTH-1:0] beat_count_t;  // wraps silently

  // which producer currently owns the output stream
  typedef enum logic {
    SRC_RAMP = 1'b0,
    SRC_LIVE = 1'b1
  } src_sel_t;

endpackage

`default_nettype wire

// File: rtl/ramp_pattern_gen.sv
`default_nettype none

module ramp_pattern_gen
  import adc_stream_pkg::*;
(
  input  wire                CLK,
  input  wire                ARESETN,
  input  wire  ramp_limit_t  ramp_limit,
  input  wire  logic         ramp_advance,
  output beat_t              ramp_word,
  output logic               ramp_valid
);

  ramp_limit_t                  limit_q;
  ramp_limit_t                  wrap_diff;
  logic                         wrap_en;
  logic [LANE_NUM*LANE_PAD-1:0] pad_bits;

  // ******************************
  // wrap decision
  // ******************************

  // top lane sample, zero extended into the signed range, minus the limit
  assign wrap_diff = ramp_limit_t'({1'b0, ramp_word[BEAT_WIDTH-1 -: ADC_RES]}) - limit_q;
  assign wrap_en   = (wrap_diff >= limit_q);

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      limit_q <= ramp_limit;  // sampled for as long as reset is held
    end
  end

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      ramp_valid <= 1'b0;
    end else begin
      ramp_valid <= 1'b1;  // the ramp never runs dry
    end
  end

  // ******************************
  // ramp word
  // ******************************

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      ramp_word <= '0;
    end else if (ramp_advance) begin
      if (wrap_en) begin
        ramp_word <= '0;
      end else begin
        for (int i = 0; i < LANE_NUM; i++) begin
          // even lanes step by one, odd lanes by two
          ramp_word[i*LANE_WIDTH +: LANE_WIDTH] <=
            {ramp_word[i*LANE_WIDTH+LANE_PAD +: ADC_RES] + adc_sample_t'((i % 2) + 1),
             {LANE_PAD{1'b0}}};
        end
      end
    end
  end

  // gather the pad bits of all lanes for the check below
  for (genvar g = 0; g < LANE_NUM; g++) begin : g_pad
    assign pad_bits[g*LANE_PAD +: LANE_PAD] = ramp_word[g*LANE_WIDTH +: LANE_PAD];
  end

  // the left-justified format must survive every advance and wrap
  a_pad_zero: assert property (
    @(posedge CLK) disable iff (!ARESETN)
    ramp_advance |=> (pad_bits == '0)
  ) else $error("ramp lane pad bits not zero");

endmodule

`default_nettype wire

// File: rtl/adc_lane_packer.sv
`default_nettype none

module adc_lane_packer
  import adc_stream_pkg::*;
(
  input  wire                CLK,
  input  wire                ARESETN,
  input  wire  logic         adc_strobe,
  input  wire  adc_sample_t  adc_sample,
  input  wire  logic         word_take,
  output beat_t              live_word,
  output logic               word_valid,
  output logic               overflow
);

  lane_idx_t lane_idx;
  beat_t     collect_word;
  beat_t     packed_word;
  logic      word_done;
  logic      hold_free;

  // ******************************
  // lane collection
  // ******************************

  // current collecting word with the strobed sample dropped into its lane
  always_comb begin
    packed_word = collect_word;
    packed_word[lane_idx*LANE_WIDTH +: LANE_WIDTH] = {adc_sample, {LANE_PAD{1'b0}}};
  end

  assign word_done = adc_strobe && (lane_idx == lane_idx_t'(LANE_NUM - 1));
  assign hold_free = !word_valid || word_take;  // hold empties on this edge if taken

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      lane_idx <= '0;
    end else if (adc_strobe) begin
      lane_idx <= lane_idx + lane_idx_t'(1);  // wraps back to lane 0 after the last lane
    end
  end

  always_ff @(posedge CLK) begin
    if (adc_strobe) begin
      collect_word <= packed_word;
    end
  end

  // ******************************
  // one word hold
  // ******************************

  always_ff @(posedge CLK) begin
    if (word_done && hold_free) begin
      live_word <= packed_word;
    end
  end

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      word_valid <= 1'b0;
    end else if (word_done && hold_free) begin
      word_valid <= 1'b1;
    end else if (word_take) begin
      word_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      overflow <= 1'b0;
    end else if (word_done && !hold_free) begin
      overflow <= 1'b1;  // new word lost, sticky until reset
    end
  end

  // the selector may only take a word that is actually held
  a_take_needs_valid: assert property (
    @(posedge CLK) disable iff (!ARESETN)
    word_take |-> word_valid
  ) else $error("word_take without a held word");

endmodule

`default_nettype wire

// File: rtl/stream_source_select.sv
`default_nettype none

module stream_source_select
  import adc_stream_pkg::*;
(
  input  wire                CLK,
  input  wire                ARESETN,
  input  wire  src_sel_t     src_sel,
  input  wire  beat_t        ramp_word,
  input  wire  logic         ramp_valid,
  input  wire  beat_t        live_word,
  input  wire  logic         word_valid,
  input  wire  logic         tready,
  output beat_t              tdata,
  output logic               tvalid,
  output logic               ramp_advance,
  output logic               word_take,
  output beat_count_t        beat_count
);

  src_sel_t active_src;
  logic     beat_accept;
  logic     beat_boundary;

  // ******************************
  // source selection
  // ******************************

  assign beat_accept   = tvalid && tready;
  assign beat_boundary = !tvalid || beat_accept;  // nothing left pending after this edge

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      active_src <= SRC_RAMP;
    end else if (beat_boundary) begin
      active_src <= src_sel;
    end
  end

  always_comb begin
    if (active_src == SRC_LIVE) begin
      tvalid = word_valid;
      tdata  = live_word;
    end else begin
      tvalid = ramp_valid;
      tdata  = ramp_word;
    end
  end

  // only the source that delivered the beat sees the accept
  assign ramp_advance = beat_accept && (active_src == SRC_RAMP);
  assign word_take    = beat_accept && (active_src == SRC_LIVE);

  // ******************************
  // beat counter
  // ******************************

  always_ff @(posedge CLK) begin
    if (!ARESETN) begin
      beat_count <= '0;
    end else if (beat_accept) begin
      beat_count <= beat_count + beat_count_t'(1);
    end
  end

  // a stalled beat must stay with the source that offered it
  a_hold_src_on_stall: assert property (
    @(posedge CLK) disable iff (!ARESETN)
    (tvalid && !tready) |=> $stable(active_src) && tvalid && $stable(tdata)
  ) else $error("stalled beat changed under back-pressure");

endmodule

`default_nettype wire

// File: rtl/adc_stream_top.sv
`default_nettype none

module adc_stream_top
  import adc_stream_pkg::*;
(
  input  wire                CLK,
  input  wire                ARESETN,
  input  wire  ramp_limit_t  ramp_limit,
  input  wire  src_sel_t     src_sel,
  input  wire  logic         adc_strobe,
  input  wire  adc_sample_t  adc_sample,
  input  wire  logic         tready,
  output beat_t              tdata,
  output logic               tvalid,
  output beat_count_t        beat_count,
  output logic               overflow
);

  beat_t ramp_word;
  logic  ramp_valid;
  logic  ramp_advance;
  beat_t live_word;
  logic  word_valid;
  logic  word_take;

  // ******************************
  // sources
  // ******************************

  ramp_pattern_gen ramp_i (
    .CLK          (CLK),
    .ARESETN      (ARESETN),
    .ramp_limit   (ramp_limit),
    .ramp_advance (ramp_advance),
    .ramp_word    (ramp_word),
    .ramp_valid   (ramp_valid)
  );

  adc_lane_packer packer_i (
    .CLK        (CLK),
    .ARESETN    (ARESETN),
    .adc_strobe (adc_strobe),
    .adc_sample (adc_sample),
    .word_take  (word_take),
    .live_word  (live_word),
    .word_valid (word_valid),
    .overflow   (overflow)
  );

  // ******************************
  // output stream
  // ******************************

  stream_source_select select_i (
    .CLK          (CLK),
    .ARESETN      (ARESETN),
    .src_sel      (src_sel),
    .ramp_word    (ramp_word),
    .ramp_valid   (ramp_valid),
    .live_word    (live_word),
    .word_valid   (word_valid),
    .tready       (tready),
    .tdata        (tdata),
    .tvalid       (tvalid),
    .ramp_advance (ramp_advance),
    .word_take    (word_take),
    .beat_count   (beat_count)
  );

endmodule

`default_nettype wire

// File: testbench/tb_adc_stream.sv
`default_nettype none

module tb_adc_stream
  import adc_stream_pkg::*;
();

  // ******************************
  // run constants
  // ******************************

  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_MARGIN = 32;
  localparam int HEADER_WORDS   = 2;     // ramp limit and line count
  localparam int FIELDS         = 9;     // words per pattern line
  localparam int PATTERN_DEPTH  = 2048;

  logic        CLK;
  logic        ARESETN;
  ramp_limit_t ramp_limit;
  src_sel_t    src_sel;
  logic        adc_strobe;
  adc_sample_t adc_sample;
  logic        tready;
  beat_t       tdata;
  logic        tvalid;
  beat_count_t beat_count;
  logic        overflow;

  beat_t pattern_mem [0:PATTERN_DEPTH-1];
  int    num_lines;
  int    cycle_count   = 0;
  int    timeout_limit = RESET_CYCLES + TIMEOUT_MARGIN;

  adc_stream_top dut_i (
    .CLK        (CLK),
    .ARESETN    (ARESETN),
    .ramp_limit (ramp_limit),
    .src_sel    (src_sel),
    .adc_strobe (adc_strobe),
    .adc_sample (adc_sample),
    .tready     (tready),
    .tdata      (tdata),
    .tvalid     (tvalid),
    .beat_count (beat_count),
    .overflow   (overflow)
  );

  initial begin
    CLK = 1'b0;
    forever begin
      #2 CLK = ~CLK;
    end
  end

  // ******************************
  // failure handling
  // ******************************

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic string label_for_test(input beat_t test_id);
    case (int'(test_id))
      1:       return "ramp after reset";
      2:       return "back-pressure";
      3:       return "ramp wrap";
      4:       return "live packing";
      5:       return "overflow";
      6:       return "source switching";
      default: return "unknown test";
    endcase
  endfunction

  task automatic check_beat(input string name, input beat_t expected, input beat_t actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %b, actual %b", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input beat_count_t expected,
                             input beat_count_t actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
      abort_run();
    end
  endtask

  // the run must end well inside the length of the pattern file
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_limit);
      abort_run();
    end
  end

  // ******************************
  // stimulus and checks
  // ******************************

  initial begin
    int    base;
    string name;

    ARESETN    = 1'b0;
    ramp_limit = '0;
    src_sel    = SRC_RAMP;
    adc_strobe = 1'b0;
    adc_sample = '0;
    tready     = 1'b0;

    $readmemh("testbench/adc_stream_patterns.txt", pattern_mem);
    ramp_limit    = ramp_limit_t'(pattern_mem[0]);  // latched by the ramp while reset is low
    num_lines     = int'(pattern_mem[1]);
    timeout_limit = num_lines + RESET_CYCLES + TIMEOUT_MARGIN;

    if (num_lines < 1 || HEADER_WORDS + num_lines * FIELDS > PATTERN_DEPTH) begin
      $display("the pattern file is missing or gives no usable line count");
      abort_run();
    end

    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    ARESETN    = 1'b1;
    ramp_limit = ~ramp_limit;  // the ramp keeps the limit it latched in reset

    for (int i = 0; i < num_lines; i++) begin
      base = HEADER_WORDS + i * FIELDS;
      name = $sformatf("%s, line %0d", label_for_test(pattern_mem[base]), i);

      src_sel    = src_sel_t'(pattern_mem[base+1][0]);
      adc_strobe = pattern_mem[base+2][0];
      adc_sample = adc_sample_t'(pattern_mem[base+3]);
      tready     = pattern_mem[base+4][0];

      #1;  // outputs settled since the last rising edge, next edge one unit away

      check_flag({name, ", tvalid"}, pattern_mem[base+5][0], tvalid);
      if (pattern_mem[base+5][0]) begin
        check_beat({name, ", tdata"}, pattern_mem[base+6], tdata);  // data only means something when valid
      end
      check_count({name, ", beat_count"}, beat_count_t'(pattern_mem[base+7]), beat_count);
      check_flag({name, ", overflow"}, pattern_mem[base+8][0], overflow);

      @(negedge CLK);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/adc_stream_patterns.txt
// header: ramp_limit line_count (hex), then one line per clock cycle after reset
// test src_sel strobe sample tready, then expected tvalid tdata beat_count overflow
004 034
// ramp after reset, limit 4 wraps once the top lane reaches 8
1 0 0 000 1 0 00000000000000000000000000000000 0000 0
1 0 0 000 1 1 00000000000000000000000000000000 0000 0
1 0 0 000 1 1 00200010002000100020001000200010 0001 0
1 0 0 000 1 1 00400020004000200040002000400020 0002 0
1 0 0 000 1 1 00600030006000300060003000600030 0003 0
3 0 0 000 1 1 00800040008000400080004000800040 0004 0
3 0 0 000 1 1 00000000000000000000000000000000 0005 0
// back-pressure holds word and count
2 0 0 000 0 1 00200010002000100020001000200010 0006 0
2 0 0 000 0 1 00200010002000100020001000200010 0006 0
2 0 0 000 0 1 00200010002000100020001000200010 0006 0
2 0 0 000 1 1 00200010002000100020001000200010 0006 0
2 0 0 000 1 1 00400020004000200040002000400020 0007 0
2 0 0 000 0 1 00600030006000300060003000600030 0008 0
// live requested under back-pressure, switch after the accept
6 1 0 000 0 1 00600030006000300060003000600030 0008 0
6 1 0 000 0 1 00600030006000300060003000600030 0008 0
6 1 0 000 1 1 00600030006000300060003000600030 0008 0
// eight strobes fill one live word
4 1 1 123 1 0 00000000000000000000000000000000 0009 0
4 1 1 456 1 0 00000000000000000000000000000000 0009 0
4 1 1 789 1 0 00000000000000000000000000000000 0009 0
4 1 1 abc 1 0 00000000000000000000000000000000 0009 0
4 1 1 def 1 0 00000000000000000000000000000000 0009 0
4 1 1 001 1 0 00000000000000000000000000000000 0009 0
4 1 1 fff 1 0 00000000000000000000000000000000 0009 0
4 1 1 800 1 0 00000000000000000000000000000000 0009 0
4 1 0 000 0 1 8000fff00010def0abc0789045601230 0009 0
4 1 0 000 1 1 8000fff00010def0abc0789045601230 0009 0
4 1 0 000 1 0 00000000000000000000000000000000 000a 0
// second word held, third word completes and is dropped
5 1 1 011 0 0 00000000000000000000000000000000 000a 0
5 1 1 022 0 0 00000000000000000000000000000000 000a 0
5 1 1 033 0 0 00000000000000000000000000000000 000a 0
5 1 1 044 0 0 00000000000000000000000000000000 000a 0
5 1 1 055 0 0 00000000000000000000000000000000 000a 0
5 1 1 066 0 0 00000000000000000000000000000000 000a 0
5 1 1 077 0 0 00000000000000000000000000000000 000a 0
5 1 1 088 0 0 00000000000000000000000000000000 000a 0
5 1 1 111 0 1 08800770066005500440033002200110 000a 0
5 1 1 222 0 1 08800770066005500440033002200110 000a 0
5 1 1 333 0 1 08800770066005500440033002200110 000a 0
5 1 1 444 0 1 08800770066005500440033002200110 000a 0
5 1 1 555 0 1 08800770066005500440033002200110 000a 0
5 1 1 666 0 1 08800770066005500440033002200110 000a 0
5 1 1 777 0 1 08800770066005500440033002200110 000a 0
5 1 1 999 0 1 08800770066005500440033002200110 000a 0
// back to the ramp under back-pressure, ramp resumes where it stopped
6 0 0 000 0 1 08800770066005500440033002200110 000a 1
6 0 0 000 1 1 08800770066005500440033002200110 000a 1
6 0 0 000 1 1 00800040008000400080004000800040 000b 1
3 0 0 000 1 1 00000000000000000000000000000000 000c 1
2 0 0 000 0 1 00200010002000100020001000200010 000d 1
2 0 0 000 0 1 00200010002000100020001000200010 000d 1
2 0 0 000 1 1 00200010002000100020001000200010 000d 1
1 0 0 000 1 1 00400020004000200040002000400020 000e 1
1 0 0 000 0 1 00600030006000300060003000600030 000f 1

// File: tb.f
rtl/adc_stream_pkg.sv
rtl/ramp_pattern_gen.sv
rtl/adc_lane_packer.sv
rtl/stream_source_select.sv
rtl/adc_stream_top.sv
testbench/tb_adc_stream.sv

// File: Makefile
TOP = tb_adc_stream

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir
